//--- flist.f
noc_pkg.sv
input_unit.sv
switch_allocator.sv
router.sv
folded_torus.sv
folded_torus_asserts.sv
tb_folded_torus.sv

//--- Bender.yml
package:
  name: folded_torus

sources:
  - noc_pkg.sv
  - input_unit.sv
  - switch_allocator.sv
  - router.sv
  - folded_torus.sv
  - target: test
    files:
      - folded_torus_asserts.sv
      - tb_folded_torus.sv

//--- tb_folded_torus.sv
`timescale 1ns/1ns

module tb_folded_torus;

    localparam int unsigned SEED        = 32'h2770c1ca;
    localparam int          BURST_FLITS = 64;
    localparam int          HOT_ROUNDS  = 2;                            // flits per hotspot sender
    localparam int          TOTAL_FLITS = 15 + 2 + HOT_ROUNDS * 15 + BURST_FLITS;
    localparam int          TIMEOUT     = 200 * TOTAL_FLITS + 500;     // cycles
    localparam int          HOT_NODE    = 2 * noc_pkg::TORUS_DIM + 2;  // node (2,2)

    logic                          clk;
    logic                          rst_n;
    noc_pkg::link_t                inject [noc_pkg::NUM_NODES];
    logic [noc_pkg::NUM_NODES-1:0] inject_grant;
    noc_pkg::link_t                eject [noc_pkg::NUM_NODES];

    noc_pkg::flit_t pending [noc_pkg::NUM_NODES][$];  // waiting at the source PE
    noc_pkg::flit_t expected [bit [31:0]];            // in flight, keyed by payload tag
    bit             delivered [bit [31:0]];
    string          test_name = "none";
    int             errors    = 0;
    int             ejected   = 0;
    int             cycles    = 0;
    int             tag       = 0;
    int             tests_run = 0;
    int             err_mark;
    int             ej_mark;

    folded_torus u_folded_torus (
        .clk          (clk),
        .rst_n        (rst_n),
        .inject       (inject),
        .inject_grant (inject_grant),
        .eject        (eject)
    );

    bind folded_torus folded_torus_asserts u_folded_torus_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .inject       (inject),
        .inject_grant (inject_grant),
        .eject        (eject),
        .link_in      (link_in_w),
        .in_grant     (grant_w)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int dest_node(input noc_pkg::flit_t f);
        return int'(f.dest_y) * noc_pkg::TORUS_DIM + int'(f.dest_x);
    endfunction

    function automatic int queued();
        int total;
        total = 0;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            total += pending[n].size();
        end
        return total;
    endfunction

    task automatic queue_flit(input int src, input int dst);
        noc_pkg::flit_t f;
        f.dest_x  = noc_pkg::coord_t'(dst % noc_pkg::TORUS_DIM);
        f.dest_y  = noc_pkg::coord_t'(dst / noc_pkg::TORUS_DIM);
        f.src_x   = noc_pkg::coord_t'(src % noc_pkg::TORUS_DIM);
        f.src_y   = noc_pkg::coord_t'(src / noc_pkg::TORUS_DIM);
        f.payload = 32'ha500_0000 | 32'(tag);           // unique tag
        tag++;
        pending[src].push_back(f);
    endtask

    task automatic wait_drain();
        while (expected.num() != 0 || queued() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
        ej_mark   = ejected;
    endtask

    task automatic report_test();
        tests_run++;
        $display("test %s done: %0d flits ejected, %0d errors",
                 test_name, ejected - ej_mark, errors - err_mark);
    endtask

    task automatic check_eject(input int node, input noc_pkg::flit_t flit);
        noc_pkg::flit_t want;
        ejected++;
        if (delivered.exists(flit.payload)) begin
            $display("payload %h ejected a second time at node %0d", flit.payload, node);
            errors++;
        end else if (!expected.exists(flit.payload)) begin
            $display("unknown payload %h ejected at node %0d", flit.payload, node);
            errors++;
        end else begin
            want = expected[flit.payload];
            assert (node == dest_node(want)) else begin
                $display("[ERROR] %s: eject node expected %0d, actual %0d",
                         test_name, dest_node(want), node);
                errors++;
            end
            assert (flit == want) else begin
                $display("[ERROR] %s: flit expected %h, actual %h", test_name, want, flit);
                errors++;
            end
            expected.delete(flit.payload);
            delivered[flit.payload] = 1'b1;
        end
    endtask

    ////////////////////
    // injection driver
    ////////////////////
    initial begin
        logic [noc_pkg::NUM_NODES-1:0] driving;
        driving = '0;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            inject[n] = '0;
        end
        forever begin
            @(posedge clk);
            for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
                if (driving[n]) begin
                    inject[n].req <= 1'b0;                          // one-cycle strobe
                    driving[n] = 1'b0;
                end else if (rst_n && inject_grant[n] && pending[n].size() > 0) begin
                    inject[n] <= {1'b1, pending[n][0]};
                    expected[pending[n][0].payload] = pending[n][0];
                    void'(pending[n].pop_front());
                    driving[n] = 1'b1;
                end
            end
        end
    end

    // eject strobes are stable mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
                if (eject[n].req) begin
                    check_eject(n, eject[n].flit);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: traffic still in flight after %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        int max_low;
        int low_run [noc_pkg::NUM_NODES];
        int src;
        int dst;
        void'($urandom(SEED));
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        start_test("reset");
        assert (inject_grant == {noc_pkg::NUM_NODES{1'b1}}) else begin
            $display("[ERROR] %s: inject_grant expected %h, actual %h",
                     test_name, {noc_pkg::NUM_NODES{1'b1}}, inject_grant);
            errors++;
        end
        repeat (20) @(negedge clk);                                 // idle window, nothing sent
        assert (ejected == 0) else begin
            $display("[ERROR] %s: eject strobes expected 0, actual %0d", test_name, ejected);
            errors++;
        end
        report_test();

        start_test("unicast");
        for (int d = 1; d < noc_pkg::NUM_NODES; d++) begin
            queue_flit(0, d);
            wait_drain();
        end
        report_test();

        start_test("self");
        queue_flit(0, 0);
        wait_drain();
        queue_flit(13, 13);
        wait_drain();
        report_test();

        start_test("hotspot");
        // later flits of a sender queue behind the first wave at the hot node
        for (int r = 0; r < HOT_ROUNDS; r++) begin
            for (int s = 0; s < noc_pkg::NUM_NODES; s++) begin
                if (s != HOT_NODE) begin
                    queue_flit(s, HOT_NODE);
                end
            end
        end
        max_low = 0;
        low_run = '{default: 0};
        while (expected.num() != 0 || queued() != 0) begin
            @(negedge clk);
            for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
                low_run[n] = inject_grant[n] ? 0 : low_run[n] + 1;
                max_low    = (low_run[n] > max_low) ? low_run[n] : max_low;
            end
        end
        // uncontended a source buffer is busy for one cycle only
        assert (max_low >= 2) else begin
            $display("[ERROR] %s: longest inject_grant low run expected >= 2, actual %0d",
                     test_name, max_low);
            errors++;
        end
        report_test();

        start_test("burst");
        for (int i = 0; i < BURST_FLITS; i++) begin
            src = int'($urandom % noc_pkg::NUM_NODES);
            dst = int'($urandom % noc_pkg::NUM_NODES);
            queue_flit(src, dst);
            @(negedge clk);                                         // one new flit per cycle
        end
        wait_drain();
        report_test();

        $display("tests run %0d, flits ejected %0d, check errors %0d, assertion failures %0d",
                 tests_run, ejected, errors, u_folded_torus.u_folded_torus_asserts.fail_count);
        if (errors == 0 && u_folded_torus.u_folded_torus_asserts.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- folded_torus_asserts.sv
`timescale 1ns/1ns

module folded_torus_asserts (
    input logic                          clk,
    input logic                          rst_n,
    input noc_pkg::link_t                inject [noc_pkg::NUM_NODES],
    input logic [noc_pkg::NUM_NODES-1:0] inject_grant,
    input noc_pkg::link_t                eject [noc_pkg::NUM_NODES],
    input noc_pkg::link_t                link_in [noc_pkg::NUM_NODES][noc_pkg::NUM_PORTS],
    input noc_pkg::port_vec_t            in_grant [noc_pkg::NUM_NODES]
);

    int unsigned fail_count = 0;    // summed up by the testbench
    logic        eject_any;

    always_comb begin
        eject_any = 1'b0;
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            eject_any = eject_any | eject[n].req;
        end
    end

    ////////////////////
    // per node checks
    ////////////////////
    for (genvar n = 0; n < noc_pkg::NUM_NODES; n++) begin : g_node
        a_inject_req: assert property (@(posedge clk) disable iff (!rst_n)
            inject[n].req |-> inject_grant[n])
        else begin
            $error("inject req at node %0d while its input buffer is full", n);
            fail_count++;
        end

        a_eject_dest: assert property (@(posedge clk) disable iff (!rst_n)
            eject[n].req |-> (eject[n].flit.dest_x == noc_pkg::coord_t'(n % noc_pkg::TORUS_DIM)
                           && eject[n].flit.dest_y == noc_pkg::coord_t'(n / noc_pkg::TORUS_DIM)))
        else begin
            $error("flit for another node ejected at node %0d", n);
            fail_count++;
        end

        // receiving end of each ring link, against the buffer level of that input
        for (genvar p = 0; p <= noc_pkg::PORT_S; p++) begin : g_link
            a_link_req: assert property (@(posedge clk) disable iff (!rst_n)
                link_in[n][p].req |-> in_grant[n][p])
            else begin
                $error("node %0d got a flit on link port %0d while that buffer was full", n, p);
                fail_count++;
            end
        end
    end

    // first cycle out of reset, all buffers empty
    a_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (&inject_grant) && !eject_any)
    else begin
        $error("grants not all high or eject active right after reset");
        fail_count++;
    end

endmodule

//--- folded_torus.sv
`timescale 1ns/1ns

module folded_torus (
    input  logic                          clk,
    input  logic                          rst_n,
    input  noc_pkg::link_t                inject [noc_pkg::NUM_NODES],
    output logic [noc_pkg::NUM_NODES-1:0] inject_grant,
    output noc_pkg::link_t                eject [noc_pkg::NUM_NODES]
);

    noc_pkg::link_t           link_in_w  [noc_pkg::NUM_NODES][noc_pkg::NUM_PORTS];
    noc_pkg::link_t           link_out_w [noc_pkg::NUM_NODES][noc_pkg::NUM_PORTS];
    noc_pkg::port_vec_t       grant_w    [noc_pkg::NUM_NODES];
    logic [noc_pkg::PORT_S:0] grant_in_w [noc_pkg::NUM_NODES];

    ////////////////////
    // router array
    ////////////////////
    for (genvar y = 0; y < noc_pkg::TORUS_DIM; y++) begin : g_row
        for (genvar x = 0; x < noc_pkg::TORUS_DIM; x++) begin : g_col
            // east of x meets west of x+1, north of y meets south of y+1
            assign link_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_E] =
                link_out_w[noc_pkg::node_idx(x + 1, y)][noc_pkg::PORT_W];
            assign link_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_W] =
                link_out_w[noc_pkg::node_idx(x + noc_pkg::TORUS_DIM - 1, y)][noc_pkg::PORT_E];
            assign link_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_N] =
                link_out_w[noc_pkg::node_idx(x, y + 1)][noc_pkg::PORT_S];
            assign link_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_S] =
                link_out_w[noc_pkg::node_idx(x, y + noc_pkg::TORUS_DIM - 1)][noc_pkg::PORT_N];
            assign link_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_PE] =
                inject[noc_pkg::node_idx(x, y)];

            // grant levels come back from the input that each output feeds
            assign grant_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_E] =
                grant_w[noc_pkg::node_idx(x + 1, y)][noc_pkg::PORT_W];
            assign grant_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_W] =
                grant_w[noc_pkg::node_idx(x + noc_pkg::TORUS_DIM - 1, y)][noc_pkg::PORT_E];
            assign grant_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_N] =
                grant_w[noc_pkg::node_idx(x, y + 1)][noc_pkg::PORT_S];
            assign grant_in_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_S] =
                grant_w[noc_pkg::node_idx(x, y + noc_pkg::TORUS_DIM - 1)][noc_pkg::PORT_N];

            assign inject_grant[noc_pkg::node_idx(x, y)] =
                grant_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_PE];
            assign eject[noc_pkg::node_idx(x, y)] =
                link_out_w[noc_pkg::node_idx(x, y)][noc_pkg::PORT_PE];

            router #(
                .NODE_X (x),
                .NODE_Y (y)
            ) u_router (
                .clk       (clk),
                .rst_n     (rst_n),
                .link_in   (link_in_w[noc_pkg::node_idx(x, y)]),
                .grant_out (grant_w[noc_pkg::node_idx(x, y)]),
                .link_out  (link_out_w[noc_pkg::node_idx(x, y)]),
                .grant_in  (grant_in_w[noc_pkg::node_idx(x, y)])
            );
        end
    end

endmodule

//--- router.sv
`timescale 1ns/1ns

module router #(
    parameter int NODE_X = 0,
    parameter int NODE_Y = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  noc_pkg::link_t           link_in [noc_pkg::NUM_PORTS],
    output noc_pkg::port_vec_t       grant_out,
    output noc_pkg::link_t           link_out [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::PORT_S:0] grant_in   // buffer free levels of the four neighbours
);

    noc_pkg::port_vec_t out_req  [noc_pkg::NUM_PORTS];
    noc_pkg::flit_t     buf_flit [noc_pkg::NUM_PORTS];
    noc_pkg::port_vec_t sel      [noc_pkg::NUM_PORTS];
    noc_pkg::port_vec_t served;

    ////////////////////
    // input units
    ////////////////////
    for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_in
        input_unit #(
            .NODE_X (NODE_X),
            .NODE_Y (NODE_Y)
        ) u_input_unit (
            .clk     (clk),
            .rst_n   (rst_n),
            .link_in (link_in[p]),
            .grant   (grant_out[p]),
            .out_req (out_req[p]),
            .flit    (buf_flit[p]),
            .served  (served[p])
        );
    end

    switch_allocator u_switch_allocator (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_req    (out_req),
        .down_grant (grant_in),
        .sel        (sel)
    );

    ////////////////////
    // crossbar
    ////////////////////
    always_comb begin
        for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            link_out[o].req  = |sel[o];             // strobe only in the winning cycle
            link_out[o].flit = '0;
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                if (sel[o][i]) begin
                    link_out[o].flit = buf_flit[i];
                end
            end
        end
    end

    // an input is served when any output picked it; one output at most
    always_comb begin
        served = '0;
        for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                served[i] = served[i] | sel[o][i];
            end
        end
    end

endmodule

//--- switch_allocator.sv
`timescale 1ns/1ns

module switch_allocator (
    input  logic                     clk,
    input  logic                     rst_n,
    input  noc_pkg::port_vec_t       out_req [noc_pkg::NUM_PORTS],  // indexed by input
    input  logic [noc_pkg::PORT_S:0] down_grant,                    // E, W, N, S
    output noc_pkg::port_vec_t       sel [noc_pkg::NUM_PORTS]       // indexed by output
);

    noc_pkg::port_idx_t ptr [noc_pkg::NUM_PORTS];   // first input to look at, per output
    noc_pkg::port_vec_t eligible;

    // ejection always sinks, so the PE output never waits
    assign eligible = {1'b1, down_grant};

    ////////////////////
    // SA stage
    ////////////////////
    always_comb begin
        logic found;
        int   idx;
        found = 1'b0;
        idx   = 0;
        for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
            sel[o] = '0;
            found  = 1'b0;
            for (int k = 0; k < noc_pkg::NUM_PORTS; k++) begin
                idx = (int'(ptr[o]) + k) % noc_pkg::NUM_PORTS;
                if (eligible[o] && !found && out_req[idx][o]) begin
                    sel[o][idx] = 1'b1;
                    found       = 1'b1;
                end
            end
        end
    end

    // pointer moves just past the winner, so the winner goes last next time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
                for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
                    if (sel[o][i]) begin
                        ptr[o] <= noc_pkg::port_idx_t'((i + 1) % noc_pkg::NUM_PORTS);
                    end
                end
            end
        end
    end

endmodule

//--- input_unit.sv
`timescale 1ns/1ns

module input_unit #(
    parameter int NODE_X = 0,
    parameter int NODE_Y = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  noc_pkg::link_t     link_in,
    output logic               grant,
    output noc_pkg::port_vec_t out_req,
    output noc_pkg::flit_t     flit,
    input  logic               served
);

    logic            full;
    logic            accept;
    noc_pkg::coord_t dx_off;
    noc_pkg::coord_t dy_off;

    assign grant  = ~full;                 // buffer free level back to the sender
    assign accept = link_in.req & ~full;

    ////////////////////
    // one-flit buffer
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (served) begin
            full <= 1'b0;                  // flit left through the crossbar on this edge
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            flit <= link_in.flit;
        end
    end

    ////////////////////
    // RCU stage
    ////////////////////
    // x offset counts eastward, y offset counts southward (y grows to the north)
    assign dx_off = flit.dest_x - noc_pkg::coord_t'(NODE_X);
    assign dy_off = noc_pkg::coord_t'(NODE_Y) - flit.dest_y;

    always_comb begin
        out_req = '0;
        if (full) begin
            if (dx_off != '0) begin                                 // X ring first
                if (dx_off == noc_pkg::coord_t'(noc_pkg::TORUS_DIM - 1)) begin
                    out_req[noc_pkg::PORT_W] = 1'b1;                // one step back is shorter
                end else begin
                    out_req[noc_pkg::PORT_E] = 1'b1;
                end
            end else if (dy_off != '0) begin
                if (dy_off == noc_pkg::coord_t'(noc_pkg::TORUS_DIM - 1)) begin
                    out_req[noc_pkg::PORT_N] = 1'b1;
                end else begin
                    out_req[noc_pkg::PORT_S] = 1'b1;
                end
            end else begin
                out_req[noc_pkg::PORT_PE] = 1'b1;                   // arrived, eject
            end
        end
    end

endmodule

//--- noc_pkg.sv
package noc_pkg;

    ////////////////////
    // network sizes
    ////////////////////
    localparam int TORUS_DIM  = 4;                      // routers per ring
    localparam int NUM_NODES  = TORUS_DIM * TORUS_DIM;  // index is y*TORUS_DIM+x
    localparam int NUM_PORTS  = 5;                      // four ring links plus the local PE
    localparam int PORT_IDX_W = $clog2(NUM_PORTS);
    localparam int COORD_W    = $clog2(TORUS_DIM);
    localparam int FLIT_W     = 40;
    localparam int PAYLOAD_W  = FLIT_W - 4 * COORD_W;   // left after two coordinate pairs

    // port indices, identical at every router
    localparam int PORT_E  = 0;
    localparam int PORT_W  = 1;
    localparam int PORT_N  = 2;
    localparam int PORT_S  = 3;
    localparam int PORT_PE = 4;                         // last, so the link ports are [PORT_S:0]

    ////////////////////
    // types
    ////////////////////
    typedef logic [COORD_W-1:0]    coord_t;
    typedef logic [NUM_PORTS-1:0]  port_vec_t;          // requests, selections, buffer-free levels
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

    // single-flit packet, destination in the top bits
    typedef struct packed {
        coord_t               dest_x;
        coord_t               dest_y;
        coord_t               src_x;
        coord_t               src_y;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

    // one direction of a router link, the grant level runs the other way
    typedef struct packed {
        logic  req;                                     // one-cycle strobe per flit
        flit_t flit;
    } link_t;

    // node index with wrap-around on both rings
    function automatic int node_idx(input int x, input int y);
        return (y % TORUS_DIM) * TORUS_DIM + (x % TORUS_DIM);
    endfunction

endpackage
